// File: common/issue_pkg.sv
package issue_pkg;

    // datapath widths
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SEQ_W      = 8;
    localparam int IMM_W      = 16;
    localparam int NUM_REGS   = 32;

    // identical execution lanes, slot 1 older and slot 0 younger
    localparam int NUM_LANES  = 2;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [SEQ_W-1:0]      seq_t;
    typedef logic [IMM_W-1:0]      imm_t;

    // addi and lui take the immediate in place of the second operand
    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_LUI
    } opcode_e;

    // one decoded instruction
    typedef struct packed {
        logic      valid;
        seq_t      seq;
        opcode_e   op;
        reg_addr_t rdst;
        reg_addr_t ra1;
        reg_addr_t ra2;
        imm_t      imm;
        logic      writes;
    } instr_t;

    // producer pair, older first; younger may be invalid
    typedef struct packed {
        instr_t older;
        instr_t younger;
    } pair_t;

    // lane input, instruction plus its operand words
    typedef struct packed {
        instr_t instr;
        word_t  rd1;
        word_t  rd2;
    } issue_t;

    // lane result register
    typedef struct packed {
        logic      valid;
        seq_t      seq;
        reg_addr_t rdst;
        logic      writes;
        word_t     value;
    } result_t;

    // retire port record
    typedef struct packed {
        logic      valid;
        seq_t      seq;
        reg_addr_t rdst;
        logic      writes;
        word_t     value;
    } retire_t;

endpackage

// File: issue/issue_queue.sv
module issue_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_req,
    input  issue_pkg::pair_t           in_pair,
    output logic                       in_ack,
    input  logic                       hold,
    output issue_pkg::instr_t          cand [1:0],
    output logic [1:0]                 issue_en,
    output logic [$clog2(QUEUE_DEPTH):0] free_count
);
    import issue_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    // instruction storage
    instr_t entries [QUEUE_DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] head_nxt;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] tail_nxt;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   n_in;
    logic [PTR_W:0]   n_out;
    logic             store;
    logic             raw_hazard;

    // pointer wrap comes free with a power-of-two depth
    assign head_nxt = head + 1'b1;
    assign tail_nxt = tail + 1'b1;

    assign free_count = (PTR_W + 1)'(QUEUE_DEPTH) - count;

    // accept on a fresh request with room for a full pair
    assign store = in_req && !in_ack && (free_count >= 2);

    assign n_in = (PTR_W + 1)'(in_pair.older.valid) + (PTR_W + 1)'(in_pair.younger.valid);

    // candidate 1 is the head, candidate 2 the entry behind it
    always_comb begin
        cand[1] = entries[head];
        cand[1].valid = (count != '0);
        cand[0] = entries[head_nxt];
        cand[0].valid = (count >= 2);
    end

    // younger may not read what the older one writes
    always_comb begin
        raw_hazard = cand[1].writes && (cand[1].rdst != '0) &&
                     ((cand[1].rdst == cand[0].ra1) || (cand[1].rdst == cand[0].ra2));
    end

    always_comb begin
        issue_en[1] = cand[1].valid && !hold;
        issue_en[0] = issue_en[1] && cand[0].valid && !raw_hazard;
    end

    assign n_out = (PTR_W + 1)'(issue_en[1]) + (PTR_W + 1)'(issue_en[0]);

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head <= head + PTR_W'(n_out);
            if (store) begin
                tail <= tail + PTR_W'(n_in);
            end
            count <= count + (store ? n_in : '0) - n_out;
        end
    end

    // older goes to the tail, younger right behind it
    always_ff @(posedge clk) begin
        if (store) begin
            if (in_pair.older.valid) begin
                entries[tail] <= in_pair.older;
            end
            if (in_pair.younger.valid) begin
                entries[tail_nxt] <= in_pair.younger;
            end
        end
    end

    // four-phase ack
    // rises the cycle after a store, falls once req is seen low
    always_ff @(posedge clk) begin
        if (reset) begin
            in_ack <= 1'b0;
        end else if (store) begin
            in_ack <= 1'b1;
        end else if (in_ack && !in_req) begin
            in_ack <= 1'b0;
        end
    end

endmodule

// File: verilog/operand_fetch.sv
module operand_fetch (
    input  issue_pkg::instr_t  cand     [issue_pkg::NUM_LANES-1:0],
    input  logic [issue_pkg::NUM_LANES-1:0] issue_en,
    input  issue_pkg::word_t   rf_data  [2*issue_pkg::NUM_LANES-1:0],
    input  issue_pkg::result_t lane_res [issue_pkg::NUM_LANES-1:0],
    input  issue_pkg::retire_t ret      [issue_pkg::NUM_LANES-1:0],
    output issue_pkg::issue_t  issue    [issue_pkg::NUM_LANES-1:0]
);
    import issue_pkg::*;

    // newest value for one source register
    // checked oldest first so later matches override
    function automatic word_t forward(reg_addr_t ra, word_t rf_val);
        word_t val;
        val = rf_val;
        if (ra != '0) begin
            // retire stage, slot 0 is newer
            for (int s = NUM_LANES - 1; s >= 0; s--) begin
                if (ret[s].valid && ret[s].writes && ret[s].rdst == ra) begin
                    val = ret[s].value;
                end
            end
            // lane stage beats retire stage
            for (int s = NUM_LANES - 1; s >= 0; s--) begin
                if (lane_res[s].valid && lane_res[s].writes && lane_res[s].rdst == ra) begin
                    val = lane_res[s].value;
                end
            end
        end
        return val;
    endfunction

    // rf_data[2s+1] carries ra1 of slot s, rf_data[2s] ra2
    always_comb begin
        for (int s = 0; s < NUM_LANES; s++) begin
            issue[s] = '0;
            if (issue_en[s]) begin
                issue[s].instr = cand[s];
                issue[s].rd1   = forward(cand[s].ra1, rf_data[2*s+1]);
                issue[s].rd2   = forward(cand[s].ra2, rf_data[2*s]);
            end
        end
    end

endmodule

// File: verilog/reg_file.sv
module reg_file (
    input  logic                clk,
    input  issue_pkg::reg_addr_t ra [3:0],
    output issue_pkg::word_t     rd [3:0],
    input  logic [1:0]          we,
    input  issue_pkg::reg_addr_t wa [1:0],
    input  issue_pkg::word_t     wd [1:0]
);
    import issue_pkg::*;

    // register 0 has no storage
    word_t regs [NUM_REGS-1:1];

    // combinational reads
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (ra[p] == '0) begin
                rd[p] = '0;
            end else begin
                rd[p] = regs[ra[p]];
            end
        end
    end

    // slot 1 first so the younger slot 0 lands last
    always_ff @(posedge clk) begin
        for (int w = 1; w >= 0; w--) begin
            if (we[w] && wa[w] != '0) begin
                regs[wa[w]] <= wd[w];
            end
        end
    end

endmodule

// File: verilog/exec_lane.sv
module exec_lane (
    input  logic               clk,
    input  logic               reset,
    input  issue_pkg::issue_t  issue,
    output issue_pkg::result_t res
);
    import issue_pkg::*;

    word_t imm_sext;
    word_t value;

    // sign-extended immediate for addi
    assign imm_sext = {{(WORD_W - IMM_W){issue.instr.imm[IMM_W-1]}}, issue.instr.imm};

    always_comb begin
        case (issue.instr.op)
            OP_ADD:  value = issue.rd1 + issue.rd2;
            OP_SUB:  value = issue.rd1 - issue.rd2;
            OP_AND:  value = issue.rd1 & issue.rd2;
            OP_OR:   value = issue.rd1 | issue.rd2;
            OP_XOR:  value = issue.rd1 ^ issue.rd2;
            // signed compare
            OP_SLT:  value = {{(WORD_W - 1){1'b0}}, $signed(issue.rd1) < $signed(issue.rd2)};
            OP_ADDI: value = issue.rd1 + imm_sext;
            // immediate into the upper half
            OP_LUI:  value = {issue.instr.imm, {(WORD_W - IMM_W){1'b0}}};
            default: value = '0;
        endcase
    end

    // result register, only valid is cleared
    always_ff @(posedge clk) begin
        if (reset) begin
            res.valid <= 1'b0;
        end else begin
            res.valid  <= issue.instr.valid;
            res.seq    <= issue.instr.seq;
            res.rdst   <= issue.instr.rdst;
            res.writes <= issue.instr.writes;
            res.value  <= value;
        end
    end

endmodule

// File: verilog/retire_unit.sv
module retire_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  issue_pkg::result_t   lane_res [issue_pkg::NUM_LANES-1:0],
    output issue_pkg::retire_t   retire   [issue_pkg::NUM_LANES-1:0],
    output logic [issue_pkg::NUM_LANES-1:0] we,
    output issue_pkg::reg_addr_t wa       [issue_pkg::NUM_LANES-1:0],
    output issue_pkg::word_t     wd       [issue_pkg::NUM_LANES-1:0],
    output logic [31:0]          retired_count
);
    import issue_pkg::*;

    logic [31:0] n_valid;

    // retire registers, one per lane
    always_ff @(posedge clk) begin
        for (int s = 0; s < NUM_LANES; s++) begin
            if (reset) begin
                retire[s].valid <= 1'b0;
            end else begin
                retire[s].valid  <= lane_res[s].valid;
                retire[s].seq    <= lane_res[s].seq;
                retire[s].rdst   <= lane_res[s].rdst;
                retire[s].writes <= lane_res[s].writes;
                retire[s].value  <= lane_res[s].value;
            end
        end
    end

    // write ports straight from the retire registers
    always_comb begin
        for (int s = 0; s < NUM_LANES; s++) begin
            we[s] = retire[s].valid && retire[s].writes && (retire[s].rdst != '0);
            wa[s] = retire[s].rdst;
            wd[s] = retire[s].value;
        end
        // same target, younger slot 0 holds the final value
        if (we[0] && we[1] && (wa[0] == wa[1])) begin
            we[1] = 1'b0;
        end
    end

    // counted as they enter the retire registers
    always_comb begin
        n_valid = '0;
        for (int s = 0; s < NUM_LANES; s++) begin
            n_valid = n_valid + 32'(lane_res[s].valid);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retired_count <= '0;
        end else begin
            retired_count <= retired_count + n_valid;
        end
    end

endmodule

// File: verilog/dual_issue_core.sv
module dual_issue_core #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_req,
    input  issue_pkg::pair_t             in_pair,
    output logic                         in_ack,
    input  logic                         hold,
    output issue_pkg::retire_t           retire [issue_pkg::NUM_LANES-1:0],
    output logic [31:0]                  retired_count,
    output logic [$clog2(QUEUE_DEPTH):0] free_count
);
    import issue_pkg::*;

    instr_t                 cand     [NUM_LANES-1:0];
    logic [NUM_LANES-1:0]   issue_en;
    reg_addr_t              rf_ra    [2*NUM_LANES-1:0];
    word_t                  rf_rd    [2*NUM_LANES-1:0];
    issue_t                 issue    [NUM_LANES-1:0];
    result_t                lane_res [NUM_LANES-1:0];
    logic [NUM_LANES-1:0]   rf_we;
    reg_addr_t              rf_wa    [NUM_LANES-1:0];
    word_t                  rf_wd    [NUM_LANES-1:0];

    issue_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_issue_queue (
        .clk        (clk),
        .reset      (reset),
        .in_req     (in_req),
        .in_pair    (in_pair),
        .in_ack     (in_ack),
        .hold       (hold),
        .cand       (cand),
        .issue_en   (issue_en),
        .free_count (free_count)
    );

    // candidate sources feed the read ports, ra1 on the odd port
    for (genvar s = 0; s < NUM_LANES; s++) begin : g_rf_addr
        assign rf_ra[2*s+1] = cand[s].ra1;
        assign rf_ra[2*s]   = cand[s].ra2;
    end

    reg_file u_reg_file (
        .clk (clk),
        .ra  (rf_ra),
        .rd  (rf_rd),
        .we  (rf_we),
        .wa  (rf_wa),
        .wd  (rf_wd)
    );

    operand_fetch u_operand_fetch (
        .cand     (cand),
        .issue_en (issue_en),
        .rf_data  (rf_rd),
        .lane_res (lane_res),
        .ret      (retire),
        .issue    (issue)
    );

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        exec_lane u_exec_lane (
            .clk   (clk),
            .reset (reset),
            .issue (issue[l]),
            .res   (lane_res[l])
        );
    end

    retire_unit u_retire_unit (
        .clk           (clk),
        .reset         (reset),
        .lane_res      (lane_res),
        .retire        (retire),
        .we            (rf_we),
        .wa            (rf_wa),
        .wd            (rf_wd),
        .retired_count (retired_count)
    );

endmodule

// File: test/tb_dual_issue.sv
module tb_dual_issue;
    import issue_pkg::*;

    localparam int QUEUE_DEPTH = 8;
    localparam int NUM_PAIRS   = 150;
    localparam int TIMEOUT     = 2000;

    // one expected retirement in program order
    typedef struct packed {
        seq_t      seq;
        reg_addr_t rdst;
        logic      writes;
        word_t     value;
        logic      dep;
    } exp_t;

    logic                         clk;
    logic                         reset;
    logic                         in_req;
    pair_t                        in_pair;
    logic                         in_ack;
    logic                         hold;
    retire_t                      retire [NUM_LANES-1:0];
    logic [31:0]                  retired_count;
    logic [$clog2(QUEUE_DEPTH):0] free_count;

    int        errors = 0;
    int        sent = 0;
    word_t     lcg_state = 32'h1aed11e0;
    seq_t      next_seq = '0;
    word_t     mregs [0:31];
    logic      prev_writes = 1'b0;
    reg_addr_t prev_rdst = '0;
    exp_t      exp_q [$];
    logic      hold_random = 1'b0;
    logic [1:0] hold_hist = '0;
    logic      prev_ack = 1'b0;
    logic [$clog2(QUEUE_DEPTH):0] prev_free = '0;

    dual_issue_core #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut (
        .clk           (clk),
        .reset         (reset),
        .in_req        (in_req),
        .in_pair       (in_pair),
        .in_ack        (in_ack),
        .hold          (hold),
        .retire        (retire),
        .retired_count (retired_count),
        .free_count    (free_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_run();
        $display("errors: %0d, sent: %0d, retired: %0d", errors, sent, retired_count);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    function automatic instr_t make_instr(opcode_e op, reg_addr_t rd, reg_addr_t a1,
                                          reg_addr_t a2, logic [15:0] imm);
        instr_t i;
        i = '0;
        i.valid  = 1'b1;
        i.op     = op;
        i.rdst   = rd;
        i.ra1    = a1;
        i.ra2    = a2;
        i.imm    = imm;
        i.writes = 1'b1;
        return i;
    endfunction

    // random ops over r0..r7 and sometimes no destination
    function automatic instr_t random_instr();
        instr_t i;
        word_t  r;
        word_t  q;
        r = lcg_next();
        q = lcg_next();
        i = make_instr(opcode_e'(r[31:29]), {2'b00, r[28:26]}, {2'b00, r[25:23]},
                       {2'b00, r[22:20]}, q[31:16]);
        i.writes = (r[19:17] != 3'd0);
        return i;
    endfunction

    // reference semantics for each opcode
    function automatic word_t model_exec(instr_t i);
        word_t a;
        word_t b;
        a = mregs[i.ra1];
        b = mregs[i.ra2];
        case (i.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_ADDI: return a + {{16{i.imm[15]}}, i.imm};
            default: return {i.imm, 16'h0000};
        endcase
    endfunction

    // run one stored instruction through the model
    task automatic record(input instr_t i);
        exp_t e;
        e.seq    = i.seq;
        e.rdst   = i.rdst;
        e.writes = i.writes;
        e.value  = model_exec(i);
        // reads the destination of the one just before it
        e.dep = prev_writes && (prev_rdst != '0) &&
                ((prev_rdst == i.ra1) || (prev_rdst == i.ra2));
        if (i.writes && i.rdst != '0) begin
            mregs[i.rdst] = e.value;
        end
        prev_writes = i.writes;
        prev_rdst   = i.rdst;
        exp_q.push_back(e);
        sent++;
    endtask

    // advance to the falling edge and let hold wander in random mode
    task automatic step();
        word_t r;
        @(negedge clk);
        r = lcg_next();
        if (!hold_random) begin
            hold = 1'b0;
        end else if (!hold && r[31:29] == 3'd0) begin
            hold = 1'b1;
        end else if (hold && r[31:28] == 4'd0) begin
            hold = 1'b0;
        end
    endtask

    task automatic wait_ack(input logic level);
        int n;
        n = 0;
        while (in_ack !== level && n < TIMEOUT) begin
            step();
            n++;
        end
        if (in_ack !== level) begin
            $display("timeout: in_ack did not go to %0b at time %0t", level, $time);
            errors++;
            end_run();
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < TIMEOUT) begin
            step();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d instructions never retired", exp_q.size());
            errors++;
            end_run();
        end
    endtask

    // full four-phase transfer with the model updated once the ack shows the store
    task automatic send_pair(input instr_t older, input instr_t younger);
        pair_t p;
        p.older   = older;
        p.younger = younger;
        p.older.seq = next_seq;
        next_seq++;
        if (p.younger.valid) begin
            p.younger.seq = next_seq;
            next_seq++;
        end
        step();
        in_pair = p;
        in_req  = 1'b1;
        wait_ack(1'b1);
        record(p.older);
        if (p.younger.valid) begin
            record(p.younger);
        end
        in_req = 1'b0;
        wait_ack(1'b0);
    endtask

    // hold as seen at each rising edge
    always @(posedge clk) begin
        hold_hist <= {hold_hist[0], hold};
    end

    // retire ports with slot 1 checked before slot 0
    always @(negedge clk) begin : monitor
        exp_t e;
        logic both;
        if (!reset) begin
            both = retire[1].valid && retire[0].valid;
            for (int s = 1; s >= 0; s--) begin
                if (retire[s].valid && exp_q.size() == 0) begin
                    $display("seq %0d retired with nothing outstanding", retire[s].seq);
                    errors++;
                end else if (retire[s].valid) begin
                    e = exp_q.pop_front();
                    check("retire.seq", 32'(retire[s].seq), 32'(e.seq));
                    check("retire.rdst", 32'(retire[s].rdst), 32'(e.rdst));
                    check("retire.writes", 32'(retire[s].writes), 32'(e.writes));
                    check("retire.value", retire[s].value, e.value);
                    if (s == 0 && both) begin
                        check("dependent pair in one cycle", 32'(e.dep), 32'd0);
                    end
                    // issue was blocked by hold at the edge that would have fed this
                    if (hold_hist[1]) begin
                        $display("seq %0d retired too long after hold rose", e.seq);
                        errors++;
                    end
                end
            end
            // ack may only rise from a store with room for a pair
            if (in_ack && !prev_ack) begin
                check("free_count before ack", 32'(prev_free >= 2), 32'd1);
            end
            prev_ack  = in_ack;
            prev_free = free_count;
        end
    end

    initial begin
        reset   = 1'b1;
        in_req  = 1'b0;
        in_pair = '0;
        hold    = 1'b0;
        for (int r = 0; r < 32; r++) begin
            mregs[r] = '0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // seed r1..r7
        send_pair(make_instr(OP_LUI, 1, 0, 0, 16'h8001), make_instr(OP_LUI, 2, 0, 0, 16'h1234));
        send_pair(make_instr(OP_LUI, 3, 0, 0, 16'h00f0), make_instr(OP_LUI, 4, 0, 0, 16'h7fff));
        send_pair(make_instr(OP_LUI, 5, 0, 0, 16'hffff), make_instr(OP_LUI, 6, 0, 0, 16'h0042));
        send_pair(make_instr(OP_LUI, 7, 0, 0, 16'h0a0a), '0);
        // dependent pairs through the bypass
        send_pair(make_instr(OP_ADDI, 1, 1, 0, 16'h0155), make_instr(OP_ADD, 3, 1, 2, 16'h0));
        send_pair(make_instr(OP_SUB, 4, 3, 4, 16'h0), make_instr(OP_SLT, 6, 4, 5, 16'h0));
        // same destination so the younger must win
        send_pair(make_instr(OP_ADDI, 5, 1, 0, 16'h0012), make_instr(OP_LUI, 5, 0, 0, 16'h00ab));
        wait_drain();
        send_pair(make_instr(OP_ADD, 6, 5, 0, 16'h0), '0);
        // random pairs under random hold
        hold_random = 1'b1;
        for (int k = 0; k < NUM_PAIRS; k++) begin
            instr_t o;
            instr_t y;
            word_t  r;
            o = random_instr();
            y = random_instr();
            r = lcg_next();
            if (r[31:30] == 2'd0) begin
                y = '0;
            end
            send_pair(o, y);
        end
        hold_random = 1'b0;
        step();
        wait_drain();
        check("retired_count", retired_count, 32'(sent));
        check("free_count", 32'(free_count), 32'(QUEUE_DEPTH));
        end_run();
    end

endmodule

// File: compile.f
common/issue_pkg.sv
issue/issue_queue.sv
verilog/operand_fetch.sv
verilog/reg_file.sv
verilog/exec_lane.sv
verilog/retire_unit.sv
verilog/dual_issue_core.sv
test/tb_dual_issue.sv

// File: Makefile
# Verilator build for the dual-issue testbench
VERILATOR ?= verilator
TOP       ?= tb_dual_issue
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= TEST RESULT: FAIL
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "no result found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
